// File: logic/core_pkg.sv
package core_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths

  localparam int addr_width = 16;
  localparam int data_width = 32;
  localparam int cord_width = 4;
  localparam int len_width  = 3;
  localparam int flit_width = 16;

  // Address bit that steers a request to the east link
  localparam int east_sel_bit = 15;

  // Tag frame is a 2-bit id then a 4-bit payload, lsb first
  localparam int tag_id_bits    = 2;
  localparam int tag_frame_bits = 6;

  // Body flit counts
  localparam int load_len  = 1;
  localparam int store_len = 3;

  // Zero bits above opcode, length and cord in the header
  localparam int hdr_pad_width = flit_width - 2 - len_width - cord_width;

  ////////////////////////////////////////////////////////////////////////////
  // Types

  typedef logic [flit_width-1:0] flit_t;

  typedef enum logic [1:0] {
    OP_LOAD    = 2'd0,
    OP_STORE   = 2'd1,
    OP_AMO_ADD = 2'd2
  } mc_op_e;

  typedef enum logic [1:0] {
    TAG_RESET  = 2'd0,
    TAG_CORD_W = 2'd1,
    TAG_CORD_E = 2'd2
  } tag_id_e;

  typedef enum logic [1:0] {
    PK_IDLE,
    PK_HDR,
    PK_BODY
  } pk_state_e;

endpackage

// File: logic/tag_client.sv
`timescale 1ns/1ns

module tag_client
  (input                                 hb_clk_i
  ,input                                 rst_i
  ,input                                 tag_data_i
  ,input                                 tag_en_i
  ,output logic                          hb_reset_o
  ,output logic [core_pkg::cord_width-1:0] cord_w_o
  ,output logic [core_pkg::cord_width-1:0] cord_e_o
  );

  localparam int cnt_width = $clog2(core_pkg::tag_frame_bits + 1);

  logic [core_pkg::tag_frame_bits-1:0] shift_r;
  logic [cnt_width-1:0]                cnt_r;
  logic                                frame_done;
  core_pkg::tag_id_e                   frame_id;
  logic [core_pkg::cord_width-1:0]     frame_payload;

  // First bit in ends up at bit 0
  always_ff @(posedge hb_clk_i) begin
    if (tag_en_i) begin
      shift_r <= {tag_data_i, shift_r[core_pkg::tag_frame_bits-1:1]};
    end
  end

  assign frame_done    = (cnt_r == cnt_width'(core_pkg::tag_frame_bits));
  assign frame_id      = core_pkg::tag_id_e'(shift_r[core_pkg::tag_id_bits-1:0]);
  assign frame_payload = shift_r[core_pkg::tag_frame_bits-1:core_pkg::tag_id_bits];

  // A frame is applied on the edge after its last bit
  always_ff @(posedge hb_clk_i) begin
    if (rst_i) begin
      cnt_r <= '0;
    end else if (frame_done) begin
      cnt_r <= tag_en_i ? cnt_width'(1) : '0;
    end else if (tag_en_i) begin
      cnt_r <= cnt_r + 1'b1;
    end else begin
      // Broken frame is dropped
      cnt_r <= '0;
    end
  end

  always_ff @(posedge hb_clk_i) begin
    if (rst_i) begin
      hb_reset_o <= 1'b1;
      cord_w_o   <= '0;
      cord_e_o   <= '0;
    end else if (frame_done) begin
      case (frame_id)
        core_pkg::TAG_RESET:  hb_reset_o <= frame_payload[0];
        core_pkg::TAG_CORD_W: cord_w_o   <= frame_payload;
        core_pkg::TAG_CORD_E: cord_e_o   <= frame_payload;
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks

  a_cnt_bound: assert property (
    @(posedge hb_clk_i) disable iff (rst_i)
    cnt_r <= cnt_width'(core_pkg::tag_frame_bits)
  ) else $error("tag bit count above frame length");

endmodule

// File: logic/request_decoder.sv
`timescale 1ns/1ns

module request_decoder
  (input                                   hb_clk_i
  ,input                                   rst_i
  ,input                                   hb_reset_i
  ,input                                   req_v_i
  ,input  core_pkg::mc_op_e                req_op_i
  ,input  [core_pkg::addr_width-1:0]       req_addr_i
  ,input  [core_pkg::data_width-1:0]       req_data_i
  ,output logic                            dec_v_o
  ,output logic                            dec_east_o
  ,output core_pkg::mc_op_e                dec_op_o
  ,output logic [core_pkg::len_width-1:0]  dec_len_o
  ,output logic [core_pkg::addr_width-1:0] dec_addr_o
  ,output logic [core_pkg::data_width-1:0] dec_data_o
  ,output logic                            err_o
  );

  logic                           accept;
  logic                           op_legal;
  logic [core_pkg::len_width-1:0] len;

  assign accept   = req_v_i & ~hb_reset_i;
  assign op_legal = req_op_i inside {core_pkg::OP_LOAD, core_pkg::OP_STORE,
                                     core_pkg::OP_AMO_ADD};

  always_comb begin
    case (req_op_i)
      core_pkg::OP_LOAD: len = core_pkg::len_width'(core_pkg::load_len);
      default:           len = core_pkg::len_width'(core_pkg::store_len);
    endcase
  end

  always_ff @(posedge hb_clk_i) begin
    if (rst_i) begin
      dec_v_o <= 1'b0;
      err_o   <= 1'b0;
    end else begin
      dec_v_o <= accept & op_legal;
      err_o   <= accept & ~op_legal;
    end
  end

  // Request fields
  always_ff @(posedge hb_clk_i) begin
    if (req_v_i) begin
      dec_east_o <= req_addr_i[core_pkg::east_sel_bit];
      dec_op_o   <= req_op_i;
      dec_len_o  <= len;
      dec_addr_o <= req_addr_i;
      dec_data_o <= req_data_i;
    end
  end

  a_err_xor_v: assert property (
    @(posedge hb_clk_i) disable iff (rst_i)
    !(err_o && dec_v_o)
  ) else $error("decoder raised err and valid together");

endmodule

// File: logic/flit_packer.sv
`timescale 1ns/1ns

module flit_packer
  (input                                   hb_clk_i
  ,input                                   rst_i
  ,input                                   hb_reset_i
  ,input                                   dec_v_i
  ,input                                   dec_east_i
  ,input  core_pkg::mc_op_e                dec_op_i
  ,input  [core_pkg::len_width-1:0]        dec_len_i
  ,input  [core_pkg::addr_width-1:0]       dec_addr_i
  ,input  [core_pkg::data_width-1:0]       dec_data_i
  ,input  [core_pkg::cord_width-1:0]       cord_w_i
  ,input  [core_pkg::cord_width-1:0]       cord_e_i
  ,output logic                            west_v_o
  ,output core_pkg::flit_t                 west_flit_o
  ,output logic                            east_v_o
  ,output core_pkg::flit_t                 east_flit_o
  ,output logic                            pk_busy_o
  );

  localparam int payload_width = core_pkg::data_width + core_pkg::addr_width;

  core_pkg::pk_state_e             state_r;
  logic [core_pkg::len_width-1:0]  cnt_r;
  logic                            east_r;
  core_pkg::mc_op_e                op_r;
  logic [core_pkg::len_width-1:0]  len_r;
  logic [core_pkg::cord_width-1:0] cord_r;
  logic [payload_width-1:0]        payload_r;
  core_pkg::flit_t                 flit;
  logic                            flit_v;

  ////////////////////////////////////////////////////////////////////////////
  // Control FSM

  always_ff @(posedge hb_clk_i) begin
    if (rst_i || hb_reset_i) begin
      state_r <= core_pkg::PK_IDLE;
      cnt_r   <= '0;
    end else begin
      case (state_r)
        core_pkg::PK_IDLE: begin
          if (dec_v_i) begin
            state_r <= core_pkg::PK_HDR;
            cnt_r   <= dec_len_i;
          end
        end
        core_pkg::PK_HDR: begin
          state_r <= core_pkg::PK_BODY;
        end
        core_pkg::PK_BODY: begin
          cnt_r <= cnt_r - 1'b1;
          if (cnt_r == core_pkg::len_width'(1)) begin
            state_r <= core_pkg::PK_IDLE;
          end
        end
        default: state_r <= core_pkg::PK_IDLE;
      endcase
    end
  end

  // Packet fields; body words leave from the bottom of payload_r
  always_ff @(posedge hb_clk_i) begin
    if (state_r == core_pkg::PK_IDLE && dec_v_i) begin
      east_r    <= dec_east_i;
      op_r      <= dec_op_i;
      len_r     <= dec_len_i;
      cord_r    <= dec_east_i ? cord_e_i : cord_w_i;
      payload_r <= {dec_data_i, dec_addr_i};
    end else if (state_r == core_pkg::PK_BODY) begin
      payload_r <= payload_r >> core_pkg::flit_width;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Link outputs

  always_comb begin
    if (state_r == core_pkg::PK_HDR) begin
      flit = {{core_pkg::hdr_pad_width{1'b0}}, op_r, len_r, cord_r};
    end else begin
      flit = payload_r[core_pkg::flit_width-1:0];
    end
  end

  assign flit_v      = (state_r == core_pkg::PK_HDR) || (state_r == core_pkg::PK_BODY);
  assign west_v_o    = flit_v & ~east_r;
  assign east_v_o    = flit_v & east_r;
  assign west_flit_o = west_v_o ? flit : '0;
  assign east_flit_o = east_v_o ? flit : '0;
  assign pk_busy_o   = (state_r != core_pkg::PK_IDLE);

  a_one_side: assert property (
    @(posedge hb_clk_i) disable iff (rst_i)
    !(west_v_o && east_v_o)
  ) else $error("flit driven on both links");

endmodule

// File: logic/core_complex.sv
`timescale 1ns/1ns

module core_complex
  (input                              hb_clk_i
  ,input                              rst_i
  ,input                              tag_data_i
  ,input                              tag_en_i
  ,input                              req_v_i
  ,input  core_pkg::mc_op_e           req_op_i
  ,input  [core_pkg::addr_width-1:0]  req_addr_i
  ,input  [core_pkg::data_width-1:0]  req_data_i
  ,output logic                       west_v_o
  ,output core_pkg::flit_t            west_flit_o
  ,output logic                       east_v_o
  ,output core_pkg::flit_t            east_flit_o
  ,output logic                       busy_o
  ,output logic                       err_o
  ,output logic                       hb_reset_o
  );

  logic                            hb_reset;
  logic [core_pkg::cord_width-1:0] cord_w;
  logic [core_pkg::cord_width-1:0] cord_e;
  logic                            dec_v;
  logic                            dec_east;
  core_pkg::mc_op_e                dec_op;
  logic [core_pkg::len_width-1:0]  dec_len;
  logic [core_pkg::addr_width-1:0] dec_addr;
  logic [core_pkg::data_width-1:0] dec_data;
  logic                            pk_busy;

  ////////////////////////////////////////////////////////////////////////////
  // Configuration

  tag_client u_tag_client
    (.hb_clk_i   (hb_clk_i)
    ,.rst_i      (rst_i)
    ,.tag_data_i (tag_data_i)
    ,.tag_en_i   (tag_en_i)
    ,.hb_reset_o (hb_reset)
    ,.cord_w_o   (cord_w)
    ,.cord_e_o   (cord_e)
    );

  ////////////////////////////////////////////////////////////////////////////
  // Request path

  request_decoder u_request_decoder
    (.hb_clk_i   (hb_clk_i)
    ,.rst_i      (rst_i)
    ,.hb_reset_i (hb_reset)
    ,.req_v_i    (req_v_i)
    ,.req_op_i   (req_op_i)
    ,.req_addr_i (req_addr_i)
    ,.req_data_i (req_data_i)
    ,.dec_v_o    (dec_v)
    ,.dec_east_o (dec_east)
    ,.dec_op_o   (dec_op)
    ,.dec_len_o  (dec_len)
    ,.dec_addr_o (dec_addr)
    ,.dec_data_o (dec_data)
    ,.err_o      (err_o)
    );

  flit_packer u_flit_packer
    (.hb_clk_i    (hb_clk_i)
    ,.rst_i       (rst_i)
    ,.hb_reset_i  (hb_reset)
    ,.dec_v_i     (dec_v)
    ,.dec_east_i  (dec_east)
    ,.dec_op_i    (dec_op)
    ,.dec_len_i   (dec_len)
    ,.dec_addr_i  (dec_addr)
    ,.dec_data_i  (dec_data)
    ,.cord_w_i    (cord_w)
    ,.cord_e_i    (cord_e)
    ,.west_v_o    (west_v_o)
    ,.west_flit_o (west_flit_o)
    ,.east_v_o    (east_v_o)
    ,.east_flit_o (east_flit_o)
    ,.pk_busy_o   (pk_busy)
    );

  // Busy covers the decoded request before the packer picks it up
  assign busy_o     = pk_busy | dec_v;
  assign hb_reset_o = hb_reset;

endmodule

// File: testbench/core_complex_tb.sv
`timescale 1ns/1ns

module core_complex_tb;

  localparam int timeout_cycles = 50;

  logic                            hb_clk_i = 1'b0;
  logic                            rst_i;
  logic                            tag_data_i;
  logic                            tag_en_i;
  logic                            req_v_i;
  core_pkg::mc_op_e                req_op_i;
  logic [core_pkg::addr_width-1:0] req_addr_i;
  logic [core_pkg::data_width-1:0] req_data_i;
  logic                            west_v_o;
  core_pkg::flit_t                 west_flit_o;
  logic                            east_v_o;
  core_pkg::flit_t                 east_flit_o;
  logic                            busy_o;
  logic                            err_o;
  logic                            hb_reset_o;

  int              errors = 0;
  int              checks = 0;
  bit              aborted = 1'b0;
  logic            exp_reset;
  logic [31:0]     rng_state = 32'h170f7a8c;
  core_pkg::flit_t exp_flits [4];

  core_complex DUT
    (.hb_clk_i    (hb_clk_i)
    ,.rst_i       (rst_i)
    ,.tag_data_i  (tag_data_i)
    ,.tag_en_i    (tag_en_i)
    ,.req_v_i     (req_v_i)
    ,.req_op_i    (req_op_i)
    ,.req_addr_i  (req_addr_i)
    ,.req_data_i  (req_data_i)
    ,.west_v_o    (west_v_o)
    ,.west_flit_o (west_flit_o)
    ,.east_v_o    (east_v_o)
    ,.east_flit_o (east_flit_o)
    ,.busy_o      (busy_o)
    ,.err_o       (err_o)
    ,.hb_reset_o  (hb_reset_o)
    );

  always #20 hb_clk_i = ~hb_clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flit(input core_pkg::flit_t exp, input logic east);
    core_pkg::flit_t got;
    got = east ? east_flit_o : west_flit_o;
    check_flag("east_v_o", east_v_o, east);
    check_flag("west_v_o", west_v_o, ~east);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %h expected %h", east ? "east_flit_o" : "west_flit_o", got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus

  // Fewer than 6 bits breaks the frame off
  task automatic shift_frame(input logic [1:0] id, input logic [3:0] payload, input int nbits);
    logic [5:0] bits;
    bits = {payload, id};
    for (int i = 0; i < nbits; i++) begin
      @(posedge hb_clk_i);
      #5;
      tag_en_i   = 1'b1;
      tag_data_i = bits[i];
    end
    @(posedge hb_clk_i);
    #5;
    tag_en_i = 1'b0;
    if (nbits == 6 && id == 2'd0) begin
      exp_reset = payload[0];
    end
    // Register lands one cycle after the last bit
    @(posedge hb_clk_i);
    @(negedge hb_clk_i);
    check_flag("hb_reset_o", hb_reset_o, exp_reset);
  endtask

  task automatic wait_busy_low();
    int n;
    n = 0;
    @(negedge hb_clk_i);
    while (busy_o !== 1'b0) begin
      if (n == timeout_cycles) begin
        $display("Timed out waiting for busy_o to fall");
        errors++;
        aborted = 1'b1;
        return;
      end
      n++;
      @(negedge hb_clk_i);
    end
  endtask

  // n counts cycles from the strobe edge
  task automatic wait_response(input bit want_err, output int n);
    n = 1;
    @(negedge hb_clk_i);
    while (want_err ? (err_o !== 1'b1) : (west_v_o !== 1'b1 && east_v_o !== 1'b1)) begin
      // Decoded request already counts as busy
      if (!want_err && n == 1) check_flag("busy_o", busy_o, 1'b1);
      if (n == timeout_cycles) begin
        $display("Timed out waiting for %s", want_err ? "err_o" : "a flit");
        errors++;
        aborted = 1'b1;
        return;
      end
      n++;
      @(negedge hb_clk_i);
    end
  endtask

  task automatic send_request(input logic [1:0] op, input logic [15:0] addr,
                              input logic [31:0] data, input logic err);
    int n;
    int len;
    wait_busy_low();
    if (aborted) return;
    @(posedge hb_clk_i);
    #5;
    req_v_i    = 1'b1;
    req_op_i   = core_pkg::mc_op_e'(op);
    req_addr_i = addr;
    req_data_i = data;
    @(posedge hb_clk_i);
    #5;
    req_v_i = 1'b0;
    if (exp_reset) begin
      repeat (timeout_cycles) begin
        @(negedge hb_clk_i);
        check_flag("west_v_o|east_v_o|err_o", west_v_o | east_v_o | err_o, 1'b0);
      end
      return;
    end
    wait_response(err, n);
    if (aborted) return;
    if (err) begin
      if (n != 1) begin
        errors++;
        $display("err_o came %0d cycles after the strobe instead of 1", n);
      end
      repeat (4) begin
        @(negedge hb_clk_i);
        check_flag("err_o", err_o, 1'b0);
        check_flag("west_v_o|east_v_o", west_v_o | east_v_o, 1'b0);
      end
      return;
    end
    if (n != 2) begin
      errors++;
      $display("Header came %0d cycles after the strobe instead of 2", n);
    end
    len = (op == 2'd0) ? 1 : 3;
    for (int i = 0; i <= len; i++) begin
      if (i > 0) @(negedge hb_clk_i);
      check_flit(exp_flits[i], addr[15]);
      check_flag("busy_o", busy_o, 1'b1);
    end
    @(negedge hb_clk_i);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("west_v_o|east_v_o", west_v_o | east_v_o, 1'b0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main

  initial begin
    int          fd;
    int          code;
    int          test_num;
    int          errs_before;
    int          nbits;
    string       kind;
    string       line;
    string       desc;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] err;
    rst_i      = 1'b1;
    tag_data_i = 1'b0;
    tag_en_i   = 1'b0;
    req_v_i    = 1'b0;
    req_op_i   = core_pkg::OP_LOAD;
    req_addr_i = '0;
    req_data_i = '0;
    exp_reset  = 1'b1;
    test_num   = 0;
    repeat (3) @(posedge hb_clk_i);
    #5;
    rst_i = 1'b0;
    @(negedge hb_clk_i);
    check_flag("hb_reset_o", hb_reset_o, 1'b1);
    check_flag("busy_o", busy_o, 1'b0);
    check_flag("err_o", err_o, 1'b0);
    check_flag("west_v_o|east_v_o", west_v_o | east_v_o, 1'b0);
    $display("test 0 reset values: %s", errors == 0 ? "ok" : "FAILED");
    fd = $fopen("testbench/core_complex_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file");
      errors++;
    end else begin
      while (!aborted && $fscanf(fd, "%s", kind) == 1) begin
        errs_before = errors;
        if (kind.substr(0, 0) == "#") begin
          code = $fgets(line, fd);
          continue;
        end
        test_num++;
        if (kind == "T" || kind == "B") begin
          nbits = 6;
          code  = $fscanf(fd, "%h %h", op, data);
          if (kind == "B") code = $fscanf(fd, "%d", nbits);
          desc = $sformatf("%s frame id %0d payload %h", kind, op, data[3:0]);
          shift_frame(op[1:0], data[3:0], nbits);
        end else begin
          code = $fscanf(fd, "%h %h %h %h %h %h %h %h", op, addr, data, err,
                         exp_flits[0], exp_flits[1], exp_flits[2], exp_flits[3]);
          // Store and AMO data words follow the seeded generator
          if (op == 1 || op == 2) begin
            rng_state = xorshift(rng_state);
            checks++;
            if (data !== rng_state) begin
              errors++;
              $display("ERROR req_data_i got %h expected %h", data, rng_state);
            end
          end
          desc = $sformatf("request op %0d addr %h", op, addr[15:0]);
          send_request(op[1:0], addr[15:0], data, err[0]);
        end
        $display("test %0d %s: %s", test_num, desc, errors == errs_before ? "ok" : "FAILED");
      end
      $fclose(fd);
    end
    $display("%0d tests, %0d checks, %0d errors", test_num + 1, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: testbench/core_complex_vectors.txt
# T id payload, or B id payload nbits for a frame broken off
# R op addr data err flit0 flit1 flit2 flit3 (hex, header first)
R 0 0010 00000000 0 0000 0000 0000 0000
T 1 5
T 2 a
T 0 0
R 0 0124 00000000 0 0015 0124 0000 0000
R 1 8040 f38e52c3 0 00ba 8040 52c3 f38e
R 2 9abc 0313eb28 0 013a 9abc eb28 0313
R 3 0200 00000000 1 0000 0000 0000 0000
B 1 c 3
R 0 1000 00000000 0 0015 1000 0000 0000
T 3 7
R 1 7ffe b0ac5673 0 00b5 7ffe 5673 b0ac
R 0 c000 00000000 0 001a c000 0000 0000
T 2 3
R 0 8000 00000000 0 0013 8000 0000 0000

// File: all.f
logic/core_pkg.sv
logic/tag_client.sv
logic/request_decoder.sv
logic/flit_packer.sv
logic/core_complex.sv
testbench/core_complex_tb.sv

// File: Bender.yml
package:
  name: core_complex

sources:
  - logic/core_pkg.sv
  - logic/tag_client.sv
  - logic/request_decoder.sv
  - logic/flit_packer.sv
  - logic/core_complex.sv
  - target: test
    files:
      - testbench/core_complex_tb.sv
